//--- list.f
hdl/nocPkg.sv
hdl/arbPkg.sv
hdl/tenureTimer.sv
hdl/outputArbiter.sv
hdl/flitSwitch.sv
hdl/routerOutputPort.sv
tb/routerOutputPortTb.sv

//--- tb/routerOutputPortTb.sv
`timescale 1ns/1ps
`default_nettype none

module routerOutputPortTb
  import nocPkg::*;
();

  typedef struct packed {
    portVec_t               req;
    pktLen_t [numPorts-1:0] lens;
    logic [15:0]            salt;      // Mixed into the random payloads.
    portVec_t               expGrant;  // Grant after the next rising edge.
  } stimRow_t;

  logic     clk;
  logic     rst;
  portVec_t req;
  flitBus_t inFlits;
  portVec_t grant;
  flit_t    outFlit;
  logic     outValid;

  stimRow_t rows[$];
  integer   seed;
  portVec_t heldGrant;  // Grant in force at the sampling edge.
  flitBus_t sentFlits;

  routerOutputPort dut0 (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .inFlits  (inFlits),
    .grant    (grant),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

  always #2 clk = ~clk;

  task automatic abortRun(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic addRow(input portVec_t r, input int lenL, lenN, lenE, lenW, lenS,
                        input logic [15:0] salt, input portVec_t expGrant);
    stimRow_t row;
    row.req      = r;
    row.lens     = {pktLen_t'(lenS), pktLen_t'(lenW), pktLen_t'(lenE),
                    pktLen_t'(lenN), pktLen_t'(lenL)};
    row.salt     = salt;
    row.expGrant = expGrant;
    rows.push_back(row);
  endtask

  function automatic int oneHotIndex(portVec_t g);
    int idx;
    idx = 0;
    for (int i = 0; i < numPorts; i++)
    begin
      if (g[i])
      begin
        idx = i;
      end
    end
    return idx;
  endfunction

  task automatic driveRow(input stimRow_t row);
    req = row.req;
    for (int p = 0; p < numPorts; p++)
    begin
      inFlits[p].id   = flitId_t'($random(seed));
      inFlits[p].len  = row.lens[p];
      inFlits[p].data = payload_t'($random(seed)) ^ row.salt;
    end
  endtask

  task automatic checkCycle(input int k);
    flit_t expFlit;
    expFlit = sentFlits[oneHotIndex(heldGrant)];
    assert (grant === rows[k].expGrant)
    else
    begin
      abortRun($sformatf("ERROR at time %0t: row %0d grant %b, expected %b",
                         $time, k, grant, rows[k].expGrant));
    end
    assert (outValid === (|heldGrant))
    else
    begin
      abortRun($sformatf("ERROR at time %0t: row %0d outValid %b, expected %b",
                         $time, k, outValid, |heldGrant));
    end
    assert (!(|heldGrant) || outFlit === expFlit)
    else
    begin
      abortRun($sformatf("ERROR at time %0t: row %0d outFlit %h/%h/%h, expected %h/%h/%h",
                         $time, k, outFlit.id, outFlit.len, outFlit.data,
                         expFlit.id, expFlit.len, expFlit.data));
    end
  endtask

  task automatic waitForIdle(input int limit, input string what);
    int cycles;
    cycles = 0;
    while (grant !== '0 || outValid !== 1'b0)
    begin
      if (cycles == limit)
      begin
        abortRun($sformatf("Timeout: the DUT never returned to idle %s.", what));
      end
      else
      begin
        @(negedge clk);
        cycles++;
      end
    end
  endtask

  initial
  begin
    clk       = 1'b0;
    rst       = 1'b1;
    req       = '0;
    inFlits   = '0;
    seed      = 15;
    heldGrant = '0;
    sentFlits = '0;

    addRow(5'b00000, 4, 6, 1, 7, 9, 16'h1d3f, 5'b00000);
    addRow(5'b00000, 4, 6, 1, 7, 9, 16'h0a42, 5'b00000);
    addRow(5'b11100, 4, 6, 1, 7, 9, 16'h77c1, 5'b00100);  // E wins over W and S.
    addRow(5'b00000, 4, 6, 1, 7, 9, 16'h3b08, 5'b00000);
    addRow(5'b11010, 4, 6, 1, 7, 9, 16'hc5e2, 5'b00010);
    addRow(5'b00000, 4, 6, 1, 7, 9, 16'h91af, 5'b00000);
    addRow(5'b11000, 4, 6, 1, 7, 9, 16'h2e6d, 5'b01000);
    addRow(5'b00000, 4, 6, 1, 7, 9, 16'hf014, 5'b00000);
    addRow(5'b11111, 2, 0, 5, 1, 3, 16'h6b93, 5'b00001);  // All request.
    addRow(5'b11111, 2, 0, 5, 1, 3, 16'h4c20, 5'b00001);
    addRow(5'b11111, 2, 0, 5, 1, 3, 16'hd81e, 5'b00001);
    addRow(5'b11111, 2, 0, 5, 1, 3, 16'h05b7, 5'b00010);  // L held 3 cycles.
    addRow(5'b11111, 2, 0, 5, 1, 3, 16'h8a6c, 5'b00100);  // N held 1 cycle.
    addRow(5'b11111, 2, 0, 5, 1, 3, 16'he249, 5'b00100);
    addRow(5'b11111, 2, 0, 5, 1, 3, 16'h1f75, 5'b00100);
    addRow(5'b11111, 2, 0, 5, 1, 3, 16'h9c03, 5'b00100);
    addRow(5'b11111, 2, 0, 5, 1, 3, 16'h3ad8, 5'b00100);
    addRow(5'b11111, 2, 0, 5, 1, 3, 16'h70e1, 5'b00100);
    addRow(5'b11111, 2, 0, 5, 1, 3, 16'hb64a, 5'b01000);  // E held 6 cycles.
    addRow(5'b11111, 2, 0, 5, 1, 3, 16'h2d9f, 5'b01000);
    addRow(5'b11111, 2, 0, 5, 1, 3, 16'hc118, 5'b10000);
    addRow(5'b11111, 2, 0, 5, 1, 3, 16'h5e36, 5'b10000);
    addRow(5'b11111, 2, 0, 5, 1, 3, 16'h83c5, 5'b10000);
    addRow(5'b11111, 2, 0, 5, 1, 3, 16'h4f0a, 5'b10000);
    addRow(5'b11111, 2, 0, 5, 1, 3, 16'ha7d2, 5'b00001);  // Wraps to L.
    addRow(5'b00001, 2, 0, 5, 1, 3, 16'h1c64, 5'b00001);
    addRow(5'b00001, 2, 0, 5, 1, 3, 16'h6e8b, 5'b00001);
    addRow(5'b00001, 2, 0, 5, 1, 3, 16'hd530, 5'b00000);  // Local scan ends in idle.
    addRow(5'b00001, 2, 0, 5, 1, 3, 16'h08f9, 5'b00001);
    addRow(5'b00110, 9, 4, 2, 6, 0, 16'hbb27, 5'b00010);  // Holder drops its request.
    addRow(5'b00100, 9, 4, 2, 6, 0, 16'h42dc, 5'b00100);
    addRow(5'b01000, 9, 4, 2, 6, 0, 16'h9e51, 5'b01000);
    addRow(5'b00001, 9, 4, 2, 6, 0, 16'h3376, 5'b00001);
    addRow(5'b10000, 9, 4, 2, 6, 0, 16'hf6a8, 5'b10000);
    addRow(5'b00001, 9, 4, 2, 6, 0, 16'h2b0d, 5'b00001);
    addRow(5'b00000, 9, 4, 2, 6, 0, 16'hc49e, 5'b00000);
    addRow(5'b00010, 2, 0, 5, 1, 3, 16'h5a13, 5'b00010);  // Lone N, len 0.
    addRow(5'b00010, 2, 0, 5, 1, 3, 16'he7b4, 5'b00000);
    addRow(5'b00010, 2, 0, 5, 1, 3, 16'h1688, 5'b00010);
    addRow(5'b00000, 2, 0, 5, 1, 3, 16'h7d2c, 5'b00000);

    repeat (8) @(negedge clk);
    rst = 1'b0;
    waitForIdle(16, "after reset");

    for (int k = 0; k < rows.size(); k++)
    begin
      driveRow(rows[k]);
      sentFlits = inFlits;
      @(negedge clk);
      checkCycle(k);
      heldGrant = rows[k].expGrant;
    end

    req = '0;
    waitForIdle(10, "after the last request");

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- hdl/routerOutputPort.sv
`timescale 1ns/1ps
`default_nettype none

module routerOutputPort
  import nocPkg::*;
(
  input  wire logic     clk,
  input  wire logic     rst,
  input  wire portVec_t req,
  input  wire flitBus_t inFlits,
  output portVec_t      grant,
  output flit_t         outFlit,
  output logic          outValid
);

  // Grant feeds back to the input ports and drives the switch.
  outputArbiter arb0 (
    .clk     (clk),
    .rst     (rst),
    .req     (req),
    .inFlits (inFlits),
    .grant   (grant)
  );

  flitSwitch sw0 (
    .clk      (clk),
    .rst      (rst),
    .grant    (grant),
    .inFlits  (inFlits),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

endmodule

`default_nettype wire

//--- hdl/flitSwitch.sv
`timescale 1ns/1ps
`default_nettype none

module flitSwitch
  import nocPkg::*;
(
  input  wire logic     clk,
  input  wire logic     rst,
  input  wire portVec_t grant,
  input  wire flitBus_t inFlits,
  output flit_t         outFlit,
  output logic          outValid
);

  flit_t selFlit;

  // Grant is one-hot, so every item is exclusive.
  always_comb
  begin
    case (grant)
      selL:
      begin
        selFlit = inFlits[portL];
      end
      selN:
      begin
        selFlit = inFlits[portN];
      end
      selE:
      begin
        selFlit = inFlits[portE];
      end
      selW:
      begin
        selFlit = inFlits[portW];
      end
      selS:
      begin
        selFlit = inFlits[portS];
      end
      default:
      begin
        selFlit = '0;  // No grant.
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outFlit  <= '0;
      outValid <= 1'b0;
    end
    else
    begin
      outFlit  <= selFlit;
      outValid <= |grant;
    end
  end

endmodule

`default_nettype wire

//--- hdl/outputArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module outputArbiter
  import nocPkg::*, arbPkg::*;
(
  input  wire logic     clk,
  input  wire logic     rst,
  input  wire portVec_t req,
  input  wire flitBus_t inFlits,
  output portVec_t      grant
);

  arbState_t state;
  arbState_t stateNext;
  portVec_t  timerRun;
  portVec_t  timerExpired;

  // State that grants port idx.
  function automatic arbState_t stateOf(int unsigned idx);
    return arbState_t'(6'b000010 << idx);
  endfunction

  // First requester among span ports, starting at first and wrapping.
  function automatic arbState_t scanReq(portVec_t r, int unsigned first, int unsigned span);
    arbState_t   pick;
    int unsigned idx;
    logic        found;
    pick  = stIdle;
    found = 1'b0;
    for (int unsigned i = 0; i < span; i++)
    begin
      idx = (first + i) % numPorts;
      if (!found && r[idx])
      begin
        pick  = stateOf(idx);
        found = 1'b1;
      end
    end
    return pick;
  endfunction

  tenureTimer timerL (
    .clk     (clk),
    .rst     (rst),
    .len     (inFlits[portL].len),
    .run     (timerRun[portL]),
    .expired (timerExpired[portL])
  );

  tenureTimer timerN (
    .clk     (clk),
    .rst     (rst),
    .len     (inFlits[portN].len),
    .run     (timerRun[portN]),
    .expired (timerExpired[portN])
  );

  tenureTimer timerE (
    .clk     (clk),
    .rst     (rst),
    .len     (inFlits[portE].len),
    .run     (timerRun[portE]),
    .expired (timerExpired[portE])
  );

  tenureTimer timerW (
    .clk     (clk),
    .rst     (rst),
    .len     (inFlits[portW].len),
    .run     (timerRun[portW]),
    .expired (timerExpired[portW])
  );

  tenureTimer timerS (
    .clk     (clk),
    .rst     (rst),
    .len     (inFlits[portS].len),
    .run     (timerRun[portS]),
    .expired (timerExpired[portS])
  );

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= stIdle;
    end
    else
    begin
      state <= stateNext;
    end
  end

  // Holder keeps the grant until it drops req or its timer expires.
  always_comb
  begin
    stateNext = stIdle;
    timerRun  = '0;
    case (state)
      stIdle:
      begin
        stateNext = scanReq(req, portL, numPorts);  // Fixed L,N,E,W,S order.
      end
      stLocal:
      begin
        if (req[portL] && !timerExpired[portL])
        begin
          timerRun[portL] = 1'b1;
          stateNext       = stLocal;
        end
        else
        begin
          stateNext = scanReq(req, portN, numPorts - 1);  // N..S, then idle.
        end
      end
      stNorth:
      begin
        if (req[portN] && !timerExpired[portN])
        begin
          timerRun[portN] = 1'b1;
          stateNext       = stNorth;
        end
        else
        begin
          stateNext = scanReq(req, portE, numPorts - 1);
        end
      end
      stEast:
      begin
        if (req[portE] && !timerExpired[portE])
        begin
          timerRun[portE] = 1'b1;
          stateNext       = stEast;
        end
        else
        begin
          stateNext = scanReq(req, portW, numPorts - 1);
        end
      end
      stWest:
      begin
        if (req[portW] && !timerExpired[portW])
        begin
          timerRun[portW] = 1'b1;
          stateNext       = stWest;
        end
        else
        begin
          stateNext = scanReq(req, portS, numPorts - 1);
        end
      end
      stSouth:
      begin
        if (req[portS] && !timerExpired[portS])
        begin
          timerRun[portS] = 1'b1;
          stateNext       = stSouth;
        end
        else
        begin
          stateNext = scanReq(req, portS + 1, numPorts - 1);  // Wraps to L.
        end
      end
      default:
      begin
        stateNext = stIdle;
      end
    endcase
  end

  assign grant = portVec_t'(state[numPorts:1]);  // Drop the idle bit.

endmodule

`default_nettype wire

//--- hdl/tenureTimer.sv
`timescale 1ns/1ps
`default_nettype none

module tenureTimer
  import nocPkg::*, arbPkg::*;
(
  input  wire logic    clk,
  input  wire logic    rst,
  input  wire pktLen_t len,
  input  wire logic    run,
  output logic         expired
);

  pktLen_t    lenQ;   // Reloaded every cycle.
  tenureCnt_t count;

  always_ff @(posedge clk)
  begin
    lenQ <= len;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      count <= '0;
    end
    else if (!run)
    begin
      count <= '0;  // Idle timer restarts.
    end
    else
    begin
      count <= count + 1'b1;
    end
  end

  assign expired = (count == lenQ);

endmodule

`default_nettype wire

//--- hdl/arbPkg.sv
`default_nettype none

package arbPkg;

  // Counter spans the full packet length range.
  localparam int cntWidth = $bits(nocPkg::pktLen_t);

  typedef logic [cntWidth-1:0] tenureCnt_t;

  // One-hot, bit 0 is idle and bits 1..5 follow the port order.
  typedef enum logic [5:0] {
    stIdle  = 6'b000001,
    stLocal = 6'b000010,
    stNorth = 6'b000100,
    stEast  = 6'b001000,
    stWest  = 6'b010000,
    stSouth = 6'b100000
  } arbState_t;

endpackage

`default_nettype wire

//--- hdl/nocPkg.sv
`default_nettype none

package nocPkg;

  localparam int numPorts = 5;

  // Bit positions in request and grant vectors.
  localparam int portL = 0;
  localparam int portN = 1;
  localparam int portE = 2;
  localparam int portW = 3;
  localparam int portS = 4;

  typedef logic [2:0]  flitId_t;  // Flit type / sequence id.
  typedef logic [11:0] pktLen_t;  // Tenure length in cycles.
  typedef logic [15:0] payload_t;

  typedef logic [numPorts-1:0] portVec_t;

  typedef struct packed {
    flitId_t  id;
    pktLen_t  len;
    payload_t data;
  } flit_t;

  typedef flit_t [numPorts-1:0] flitBus_t;  // One flit per input port.

  // One-hot grant patterns.
  localparam portVec_t selL = portVec_t'(1) << portL;
  localparam portVec_t selN = portVec_t'(1) << portN;
  localparam portVec_t selE = portVec_t'(1) << portE;
  localparam portVec_t selW = portVec_t'(1) << portW;
  localparam portVec_t selS = portVec_t'(1) << portS;

endpackage

`default_nettype wire
